// ==== source/apb_bus_pkg.sv ====
`default_nettype none

package apb_bus_pkg;

// ---------------------------------------------------------------------
// Bus widths

typedef logic [15:0] paddr_t;
typedef logic [31:0] pdata_t;

// Master to slave and held stable for the whole transfer
typedef struct packed {
	logic   psel;
	logic   penable;
	logic   pwrite;
	paddr_t paddr;
	pdata_t pwdata;
} apb_req_t;

// Slave to master
typedef struct packed {
	pdata_t prdata;
	logic   pready;
	logic   pslverr;
} apb_resp_t;

// ---------------------------------------------------------------------
// Peripheral map with one 4 kiB window per slot
//
// 0x0000  UART
// 0x1000  SPI        (empty)
// 0x2000  SDRAM cfg  (empty)
// 0x3000  Timer      (empty)
// 0x4000  GPIO       (empty)

typedef logic [3:0] slot_t;

localparam slot_t       SLOT_UART    = 4'd0;
localparam int unsigned N_PERI_SLOTS = 5;

endpackage

`default_nettype wire

// ==== source/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

// Clock cycles per bit on the line
typedef logic [15:0] baud_div_t;
typedef logic [7:0]  uart_byte_t;

// ---------------------------------------------------------------------
// Register map as offsets within the 4 kiB slot

localparam logic [11:0] UART_REG_STATUS = 12'h000;
localparam logic [11:0] UART_REG_DIV    = 12'h004;
localparam logic [11:0] UART_REG_TXDATA = 12'h008;

// Status word bits
localparam int unsigned STATUS_HOLD_FULL = 0;
localparam int unsigned STATUS_TX_BUSY   = 1;

// ---------------------------------------------------------------------
// Serializer frame states

typedef enum logic [1:0] {
	TX_IDLE,
	TX_START,
	TX_DATA,
	TX_STOP
} tx_state_t;

endpackage

`default_nettype wire

// ==== source/reset_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_sync (
	input  wire  clk_sys,
	input  wire  arst_n,
	output logic rst_n_sys
);

logic sync_q;

// Assert straight away, release through two flops
always_ff @(posedge clk_sys or negedge arst_n) begin
	if (!arst_n) begin
		sync_q    <= 1'b0;
		rst_n_sys <= 1'b0;
	end else begin
		sync_q    <= 1'b1;
		rst_n_sys <= sync_q;
	end
end

endmodule

`default_nettype wire

// ==== source/uart_tx_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_serializer import uart_pkg::*; (
	input  wire             clk_sys,
	input  wire             rst_n_sys,
	input  wire baud_div_t  div,
	input  wire             tx_load,
	input  wire uart_byte_t tx_byte,
	output logic            tx_busy,
	output logic            uart_tx
);

tx_state_t  state;
baud_div_t  bit_div;
baud_div_t  baud_cnt;
logic [2:0] bit_cnt;
uart_byte_t shift;
logic       line_q;
logic       bit_end;

assign bit_end = baud_cnt == baud_div_t'(bit_div - 1'b1);
assign tx_busy = state != TX_IDLE;
assign uart_tx = line_q;

// ---------------------------------------------------------------------
// Frame sequencing with a registered line so it never glitches

always_ff @(posedge clk_sys or negedge rst_n_sys) begin
	if (!rst_n_sys) begin
		state    <= TX_IDLE;
		baud_cnt <= '0;
		bit_cnt  <= '0;
		line_q   <= 1'b1;
	end else if (state == TX_IDLE) begin
		if (tx_load) begin
			state    <= TX_START;
			baud_cnt <= '0;
			line_q   <= 1'b0;
		end
	end else if (!bit_end) begin
		baud_cnt <= baud_cnt + 1'b1;
	end else begin
		baud_cnt <= '0;
		case (state)
			TX_START: begin
				state   <= TX_DATA;
				bit_cnt <= '0;
				line_q  <= shift[0];
			end
			TX_DATA: begin
				if (bit_cnt == 3'd7) begin
					state  <= TX_STOP;
					line_q <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
					// Next bit while the shift register moves on in the same cycle
					line_q  <= shift[1];
				end
			end
			default: begin
				state <= TX_IDLE;
			end
		endcase
	end
end

// Byte and bit length are captured at load and the byte goes out LSB first
always_ff @(posedge clk_sys) begin
	if (state == TX_IDLE && tx_load) begin
		shift   <= tx_byte;
		bit_div <= div;
	end else if (state == TX_DATA && bit_end) begin
		shift <= shift >> 1;
	end
end

endmodule

`default_nettype wire

// ==== source/uart_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_apb_regs import apb_bus_pkg::*; import uart_pkg::*; #(
	parameter baud_div_t UART_DIV_RESET = 16'd8
) (
	input  wire           clk_sys,
	input  wire           rst_n_sys,

	input  wire apb_req_t apb_req,
	output apb_resp_t     apb_resp,

	output logic          uart_tx
);

logic [11:0] reg_offset;
logic        access;
logic        sel_status;
logic        sel_div;
logic        sel_txdata;
logic        sel_known;
logic        txdata_wr;
logic        txdata_stall;

baud_div_t   div_q;
logic        hold_full;
uart_byte_t  hold_byte;
pdata_t      status_word;

logic        tx_load;
logic        tx_busy;

// ---------------------------------------------------------------------
// Address decode

assign reg_offset = apb_req.paddr[11:0];
assign access     = apb_req.psel && apb_req.penable;

assign sel_status = reg_offset == UART_REG_STATUS;
assign sel_div    = reg_offset == UART_REG_DIV;
assign sel_txdata = reg_offset == UART_REG_TXDATA;
assign sel_known  = sel_status || sel_div || sel_txdata;

// TXDATA write is held off while the previous byte is still waiting
assign txdata_stall = access && apb_req.pwrite && sel_txdata && hold_full;
assign txdata_wr    = access && apb_req.pwrite && sel_txdata && !hold_full;

// Held byte moves on as soon as the serializer is free
assign tx_load = hold_full && !tx_busy;

// ---------------------------------------------------------------------
// Registers

always_ff @(posedge clk_sys or negedge rst_n_sys) begin
	if (!rst_n_sys) begin
		div_q     <= UART_DIV_RESET;
		hold_full <= 1'b0;
	end else begin
		if (access && apb_req.pwrite && sel_div)
			div_q <= apb_req.pwdata[15:0];
		if (txdata_wr)
			hold_full <= 1'b1;
		else if (tx_load)
			hold_full <= 1'b0;
	end
end

always_ff @(posedge clk_sys) begin
	if (txdata_wr)
		hold_byte <= apb_req.pwdata[7:0];
end

always_comb begin
	status_word                   = '0;
	status_word[STATUS_HOLD_FULL] = hold_full;
	status_word[STATUS_TX_BUSY]   = tx_busy;
end

// TXDATA is write only and reads back as zero
always_comb begin
	apb_resp.pready  = !txdata_stall;
	apb_resp.pslverr = access && !sel_known;
	if (sel_status)
		apb_resp.prdata = status_word;
	else if (sel_div)
		apb_resp.prdata = pdata_t'(div_q);
	else
		apb_resp.prdata = '0;
end

// ---------------------------------------------------------------------
// Line side

uart_tx_serializer tx_u (
	.clk_sys   (clk_sys),
	.rst_n_sys (rst_n_sys),
	.div       (div_q),
	.tx_load   (tx_load),
	.tx_byte   (hold_byte),
	.tx_busy   (tx_busy),
	.uart_tx   (uart_tx)
);

endmodule

`default_nettype wire

// ==== source/apb_slot_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_slot_decoder import apb_bus_pkg::*; (
	input  wire apb_req_t  apb_req,
	output apb_resp_t      apb_resp,

	output apb_req_t       uart_req,
	input  wire apb_resp_t uart_resp
);

slot_t slot;
logic  uart_hit;

// ---------------------------------------------------------------------
// Slot selection

assign slot = apb_req.paddr[15:12];

// Only the UART slot has a slave behind it
assign uart_hit = slot == SLOT_UART;

// Request goes through as is with only psel steered
always_comb begin
	uart_req      = apb_req;
	uart_req.psel = apb_req.psel && uart_hit;
end

// ---------------------------------------------------------------------
// Response mux

// Empty and unmapped slots answer at once with an error
always_comb begin
	if (uart_hit) begin
		apb_resp = uart_resp;
	end else begin
		apb_resp.prdata  = '0;
		apb_resp.pready  = 1'b1;
		apb_resp.pslverr = apb_req.psel;
	end
end

endmodule

`default_nettype wire

// ==== source/peri_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module peri_subsystem import apb_bus_pkg::*; import uart_pkg::*; #(
	parameter baud_div_t UART_DIV_RESET = 16'd8
) (
	input  wire           clk_sys,
	input  wire           arst_n,

	input  wire apb_req_t apb_req,
	output apb_resp_t     apb_resp,

	output logic          uart_tx
);

logic      rst_n_sys;
apb_req_t  uart_req;
apb_resp_t uart_resp;

// ---------------------------------------------------------------------
// System reset

reset_sync sys_reset_sync_u (
	.clk_sys   (clk_sys),
	.arst_n    (arst_n),
	.rst_n_sys (rst_n_sys)
);

// ---------------------------------------------------------------------
// Peripheral bus

apb_slot_decoder slot_decoder_u (
	.apb_req   (apb_req),
	.apb_resp  (apb_resp),
	.uart_req  (uart_req),
	.uart_resp (uart_resp)
);

// Slot 0
uart_apb_regs #(
	.UART_DIV_RESET (UART_DIV_RESET)
) uart_u (
	.clk_sys   (clk_sys),
	.rst_n_sys (rst_n_sys),
	.apb_req   (uart_req),
	.apb_resp  (uart_resp),
	.uart_tx   (uart_tx)
);

endmodule

`default_nettype wire

// ==== tests/peri_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module peri_subsystem_tb import apb_bus_pkg::*; import uart_pkg::*; ();

localparam baud_div_t DIV_RESET  = 16'd8;
localparam int        CLK_NS     = 40;
localparam int        MAX_DIV    = 20;
localparam int        N_FRAMES   = 4;
localparam int        FRAME_BITS = 10;
localparam int        WATCHDOG_NS = N_FRAMES * FRAME_BITS * MAX_DIV * CLK_NS * 2;

logic       clk_sys;
logic       arst_n;
apb_req_t   apb_req;
apb_resp_t  apb_resp;
logic       uart_tx;

integer     seed = 63416;
int         errors = 0;
int         checks = 0;
int         stall_cycles;
int         cur_div;
uart_byte_t rx_q[$];
uart_byte_t exp_q[$];

peri_subsystem #(
	.UART_DIV_RESET (DIV_RESET)
) UUT (
	.clk_sys  (clk_sys),
	.arst_n   (arst_n),
	.apb_req  (apb_req),
	.apb_resp (apb_resp),
	.uart_tx  (uart_tx)
);

initial begin
	clk_sys = 1'b0;
	forever #(CLK_NS / 2) clk_sys = ~clk_sys;
end

initial begin
	#(WATCHDOG_NS);
	$display("Watchdog expired before the tests finished");
	$display("TESTBENCH FAILED");
	$finish;
end

// ---------------------------------------------------------------------
// Helpers

function automatic paddr_t uart_addr(input logic [11:0] offset);
	return {SLOT_UART, offset};
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	assert (got === exp) else begin
		$display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
		errors++;
	end
endtask

// Setup cycle and access cycles until pready is seen mid-cycle
task automatic apb_transfer(input logic write, input paddr_t addr, input pdata_t wdata,
		output pdata_t rdata, output logic slverr);
	@(posedge clk_sys);
	apb_req.psel    <= 1'b1;
	apb_req.penable <= 1'b0;
	apb_req.pwrite  <= write;
	apb_req.paddr   <= addr;
	apb_req.pwdata  <= wdata;
	@(posedge clk_sys);
	apb_req.penable <= 1'b1;
	stall_cycles = 0;
	@(negedge clk_sys);
	while (!apb_resp.pready) begin
		stall_cycles++;
		@(negedge clk_sys);
	end
	rdata  = apb_resp.prdata;
	slverr = apb_resp.pslverr;
	@(posedge clk_sys);
	apb_req <= '0;
endtask

task automatic apb_read(input paddr_t addr, input pdata_t exp_data, input logic exp_err);
	pdata_t rdata;
	logic   slverr;
	apb_transfer(1'b0, addr, '0, rdata, slverr);
	check_value("prdata", rdata, exp_data);
	check_value("pslverr", slverr, exp_err);
endtask

task automatic apb_write(input paddr_t addr, input pdata_t wdata, input logic exp_err);
	pdata_t rdata;
	logic   slverr;
	apb_transfer(1'b1, addr, wdata, rdata, slverr);
	check_value("pslverr", slverr, exp_err);
endtask

task automatic wait_rx_bytes(input int count);
	while (rx_q.size() < count)
		@(negedge clk_sys);
endtask

task automatic compare_rx_bytes();
	while (exp_q.size() > 0)
		check_value("uart byte", rx_q.pop_front(), exp_q.pop_front());
	check_value("extra uart bytes", rx_q.size(), 0);
endtask

task automatic report_test(input string name, input int err_mark);
	$display("Test %s: %s", name, (errors == err_mark) ? "ok" : "fail");
endtask

// ---------------------------------------------------------------------
// UART line monitor that samples each bit near its middle

initial begin
	uart_byte_t rx_byte;
	int         div_now;
	wait (arst_n === 1'b1);
	forever begin
		@(negedge uart_tx);
		div_now = cur_div;
		repeat (div_now / 2 + 1) @(negedge clk_sys);
		assert (uart_tx === 1'b0) else begin
			$display("Start bit went high before its middle");
			errors++;
		end
		for (int i = 0; i < 8; i++) begin
			repeat (div_now) @(negedge clk_sys);
			rx_byte[i] = uart_tx;
		end
		repeat (div_now) @(negedge clk_sys);
		assert (uart_tx === 1'b1) else begin
			$display("Stop bit after byte 0x%h was not high", rx_byte);
			errors++;
		end
		rx_q.push_back(rx_byte);
	end
end

// Error responses never carry data
always @(negedge clk_sys) begin
	if (arst_n && apb_resp.pslverr) begin
		assert (apb_resp.prdata === '0) else begin
			$display("CHECK FAILED: prdata got 0x%h expected 0x%h", apb_resp.prdata, 32'h0);
			errors++;
		end
	end
end

// ---------------------------------------------------------------------
// Test sequence

initial begin
	pdata_t     div_val;
	uart_byte_t tx_val;
	int         err_mark;
	int         max_stall;

	apb_req = '0;
	arst_n  = 1'b0;
	cur_div = DIV_RESET;
	repeat (5) @(posedge clk_sys);
	arst_n <= 1'b1;
	repeat (3) @(posedge clk_sys);

	err_mark = errors;
	@(negedge clk_sys);
	check_value("uart_tx", uart_tx, 1'b1);
	apb_read(uart_addr(UART_REG_STATUS), '0, 1'b0);
	apb_read(uart_addr(UART_REG_DIV), 32'(DIV_RESET), 1'b0);
	report_test("reset state", err_mark);

	err_mark = errors;
	repeat (4) begin
		div_val = 4 + {$random(seed)} % 17;
		apb_write(uart_addr(UART_REG_DIV), div_val, 1'b0);
		apb_read(uart_addr(UART_REG_DIV), div_val, 1'b0);
	end
	cur_div = div_val;
	apb_read(uart_addr(UART_REG_TXDATA), '0, 1'b0);
	report_test("divider register", err_mark);

	// Empty slots 1 to 4 and unmapped slots 5 to 15
	err_mark = errors;
	for (int s = 1; s < 16; s++) begin
		apb_read({slot_t'(s), UART_REG_DIV}, '0, 1'b1);
		apb_write({slot_t'(s), UART_REG_DIV}, 32'h2, 1'b1);
	end
	apb_read(uart_addr(12'h00C), '0, 1'b1);
	apb_write(uart_addr(12'h00C), 32'h3, 1'b1);
	apb_read(uart_addr(UART_REG_DIV), 32'(cur_div), 1'b0);
	report_test("error slots", err_mark);

	err_mark = errors;
	tx_val = $random(seed);
	apb_write(uart_addr(UART_REG_TXDATA), 32'(tx_val), 1'b0);
	exp_q.push_back(tx_val);
	wait_rx_bytes(1);
	compare_rx_bytes();
	report_test("single frame", err_mark);

	err_mark  = errors;
	max_stall = 0;
	repeat (3) begin
		tx_val = $random(seed);
		apb_write(uart_addr(UART_REG_TXDATA), 32'(tx_val), 1'b0);
		exp_q.push_back(tx_val);
		if (stall_cycles > max_stall)
			max_stall = stall_cycles;
	end
	assert (max_stall > 1) else begin
		$display("No TXDATA write was held off by the full holding register");
		errors++;
	end
	wait_rx_bytes(3);
	// Rest of the last stop bit
	repeat (cur_div) @(posedge clk_sys);
	apb_read(uart_addr(UART_REG_STATUS), '0, 1'b0);
	compare_rx_bytes();
	report_test("back-pressure", err_mark);

	$display("Checks: %0d, errors: %0d", checks, errors);
	if (errors == 0)
		$display("TESTBENCH PASSED");
	else
		$display("TESTBENCH FAILED");
	$finish;
end

endmodule

`default_nettype wire

// ==== project.f ====
source/apb_bus_pkg.sv
source/uart_pkg.sv
source/reset_sync.sv
source/uart_tx_serializer.sv
source/uart_apb_regs.sv
source/apb_slot_decoder.sv
source/peri_subsystem.sv
tests/peri_subsystem_tb.sv
